/* vlog.f */
design/his_pkg.sv
design/photon_binner.sv
design/his_builder.sv
design/his_readout.sv
design/his_top.sv
bench/tb_his_top.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_his_top
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_his_top.sv */
`timescale 1ns/10ps

module tb_his_top;

    // 0 main, 1 short frames that overrun, 2 one long frame that saturates
    localparam int N_INST = 3;
    localparam int SHIFT  = 4;
    localparam int BINS [N_INST] = '{16, 16, 8};
    localparam int PIXS [N_INST] = '{4, 4, 1};
    localparam int HPPS [N_INST] = '{3, 1, 300};
    localparam int ACQS [N_INST] = '{6, 1, 1};
    localparam int CNT_TOP = (1 << his_pkg::CNT_W) - 1;
    // above the top bin of instance 2, lands clamped
    localparam logic [7:0] SAT_CODE = 8'he7;
    localparam int MAIN_FRAMES = 6;

    logic                      clk;
    logic                      combin_res;
    logic [his_pkg::TDC_W-1:0] code [N_INST];
    logic                      strobe [N_INST];
    his_pkg::bin_word_t        bin_out [N_INST];
    logic                      busy [N_INST];
    logic                      overrun [N_INST];
    logic                      bank [N_INST];
    string                     names [N_INST] = '{"i_dut", "i_dut_fast", "i_dut_sat"};

    // model, fill histograms and closed frames awaiting readout
    int   hist [N_INST][2][8][16];
    int   snap [N_INST][2][8][16];
    int   hit_c [N_INST];
    int   pix_c [N_INST];
    int   acq_c [N_INST];
    logic fill [N_INST];
    int   frames [N_INST];
    // stream position per instance
    int   word_idx [N_INST];
    logic exp_bank [N_INST];
    int   bursts [N_INST];
    logic ovr_seen [N_INST];
    int   reuse_zero;
    int   sat_got;
    int   err_cnt;
    int   fail_cnt;
    logic [31:0] seed;

    his_top #(.N_BINS(BINS[0]), .BIN_SHIFT(SHIFT), .N_PIXELS(PIXS[0]),
              .HITS_PER_PIXEL(HPPS[0]), .N_ACQ(ACQS[0])) i_dut (
        .clk(clk), .combin_res(combin_res), .tdc_code(code[0]), .tdc_valid(strobe[0]),
        .bin_out(bin_out[0]), .busy(busy[0]), .overrun(overrun[0]), .bank(bank[0])
    );

    // four hits a frame, far shorter than one readout burst
    his_top #(.N_BINS(BINS[1]), .BIN_SHIFT(SHIFT), .N_PIXELS(PIXS[1]),
              .HITS_PER_PIXEL(HPPS[1]), .N_ACQ(ACQS[1])) i_dut_fast (
        .clk(clk), .combin_res(combin_res), .tdc_code(code[1]), .tdc_valid(strobe[1]),
        .bin_out(bin_out[1]), .busy(busy[1]), .overrun(overrun[1]), .bank(bank[1])
    );

    // single pixel, 300 hits a frame
    his_top #(.N_BINS(BINS[2]), .BIN_SHIFT(SHIFT), .N_PIXELS(PIXS[2]),
              .HITS_PER_PIXEL(HPPS[2]), .N_ACQ(ACQS[2])) i_dut_sat (
        .clk(clk), .combin_res(combin_res), .tdc_code(code[2]), .tdc_valid(strobe[2]),
        .bin_out(bin_out[2]), .busy(busy[2]), .overrun(overrun[2]), .bank(bank[2])
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // code shifted down, clamped to the last bin
    function automatic int bin_of(input int i, input logic [7:0] c);
        int b;
        b = int'(c) >> SHIFT;
        return (b > BINS[i] - 1) ? BINS[i] - 1 : b;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // frame done, fill bank frozen for readout and started empty again
    task automatic close_frame(input int i);
        for (int p = 0; p < 8; p++) begin
            for (int n = 0; n < 16; n++) begin
                // data two frames back, nothing now
                if (i == 0 && snap[i][fill[i]][p][n] != 0 && hist[i][fill[i]][p][n] == 0) begin
                    reuse_zero++;
                end
                snap[i][fill[i]][p][n] = hist[i][fill[i]][p][n];
                hist[i][fill[i]][p][n] = 0;
            end
        end
        fill[i] = ~fill[i];
        frames[i]++;
    endtask

    // one hit, counters nest hit then pixel then acquisition
    task automatic model_hit(input int i);
        int b;
        b = bin_of(i, code[i]);
        if (hist[i][fill[i]][pix_c[i]][b] < CNT_TOP) begin
            hist[i][fill[i]][pix_c[i]][b]++;
        end
        hit_c[i]++;
        if (hit_c[i] == HPPS[i]) begin
            hit_c[i] = 0;
            pix_c[i]++;
        end
        if (pix_c[i] == PIXS[i]) begin
            pix_c[i] = 0;
            acq_c[i]++;
        end
        if (acq_c[i] == ACQS[i]) begin
            acq_c[i] = 0;
            close_frame(i);
        end
    endtask

    // pixel major, bin minor, bank alternating per burst
    task automatic check_word(input int i);
        int p;
        int n;
        // after an overrun the stream mixes banks
        if (overrun[i] || ovr_seen[i]) begin
            return;
        end
        if (!bin_out[i].valid) begin
            if (word_idx[i] != 0) begin
                report_failure($sformatf("%s burst broke off after %0d words",
                                         names[i], word_idx[i]));
                word_idx[i] = 0;
            end
            return;
        end
        p = word_idx[i] / BINS[i];
        n = word_idx[i] % BINS[i];
        check_val({names[i], ".bin_out.bank"}, 32'(bin_out[i].bank), 32'(exp_bank[i]));
        check_val({names[i], ".bin_out.pixel"}, 32'(bin_out[i].pixel), 32'(p));
        check_val({names[i], ".bin_out.bin"}, 32'(bin_out[i].bin), 32'(n));
        check_val({names[i], ".bin_out.count"}, 32'(bin_out[i].count),
                  32'(snap[i][exp_bank[i]][p][n]));
        if (i == 2 && p == 0 && n == bin_of(2, SAT_CODE)) begin
            sat_got = int'(bin_out[i].count);
        end
        word_idx[i]++;
        if (word_idx[i] == PIXS[i] * BINS[i]) begin
            word_idx[i] = 0;
            exp_bank[i] = ~exp_bank[i];
            bursts[i]++;
        end
    endtask

    // outputs are settled at the falling edge, inputs from the last rise
    task automatic step();
        @(negedge clk);
        if (combin_res) begin
            for (int i = 0; i < N_INST; i++) begin
                check_word(i);
                if (ovr_seen[i] && !overrun[i]) begin
                    report_failure({names[i], " overrun dropped back low"});
                end
                ovr_seen[i] = ovr_seen[i] || overrun[i];
                if (strobe[i]) begin
                    model_hit(i);
                end
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        // main, random strobe about half the cycles
        seed = lcg_next(seed);
        strobe[0] = seed[16];
        code[0]   = seed[31:24];
        seed = lcg_next(seed);
        // back to back strobes, ten short frames
        strobe[1] = (cyc < 40);
        code[1]   = seed[31:24];
        strobe[2] = (cyc < HPPS[2]);
        code[2]   = SAT_CODE;
    endtask

    initial begin
        int cyc;
        clk        = 1'b0;
        combin_res = 1'b0;
        seed       = 32'h9d9ad18a;
        err_cnt    = 0;
        fail_cnt   = 0;
        for (int i = 0; i < N_INST; i++) begin
            strobe[i]   = 1'b0;
            code[i]     = '0;
            fill[i]     = 1'b0;
            exp_bank[i] = 1'b0;
            ovr_seen[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        combin_res = 1'b1;
        step();
        // idle outputs straight after reset
        for (int i = 0; i < N_INST; i++) begin
            check_val({names[i], ".busy"}, 32'(busy[i]), 32'd0);
            check_val({names[i], ".overrun"}, 32'(overrun[i]), 32'd0);
            check_val({names[i], ".bin_out.valid"}, 32'(bin_out[i].valid), 32'd0);
            check_val({names[i], ".bank"}, 32'(bank[i]), 32'd0);
        end
        cyc = 0;
        while (frames[0] < MAIN_FRAMES || cyc < HPPS[2]) begin
            if (cyc >= 4000) begin
                report_failure("timeout, main instance did not close its frames");
                break;
            end
            drive_inputs(cyc);
            step();
            cyc++;
        end
        for (int i = 0; i < N_INST; i++) begin
            strobe[i] = 1'b0;
        end
        // drain the last burst
        cyc = 0;
        while (bursts[0] < frames[0]) begin
            if (cyc >= 1000) begin
                report_failure("timeout, last readout burst of i_dut never finished");
                break;
            end
            step();
            cyc++;
        end
        cyc = 0;
        while (bursts[2] < 1) begin
            if (cyc >= 1000) begin
                report_failure("timeout, i_dut_sat never streamed its frame");
                break;
            end
            step();
            cyc++;
        end
        check_val("i_dut_sat.bin_out.count", 32'(sat_got), 32'(CNT_TOP));
        check_val("i_dut.overrun", 32'(overrun[0]), 32'd0);
        check_val("i_dut_sat.overrun", 32'(overrun[2]), 32'd0);
        if (!ovr_seen[1]) begin
            report_failure("i_dut_fast never raised overrun");
        end
        if (reuse_zero == 0) begin
            report_failure("no emptied entry of a reused bank was read back");
        end
        $display("errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* design/his_top.sv */
`timescale 1ns/10ps

module his_top #(
    parameter int N_BINS         = 16,
    parameter int BIN_SHIFT      = 4,
    parameter int N_PIXELS       = 4,
    parameter int HITS_PER_PIXEL = 3,
    parameter int N_ACQ          = 6
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic [his_pkg::TDC_W-1:0]  tdc_code,
    input  logic                       tdc_valid,
    output his_pkg::bin_word_t         bin_out,
    output logic                       busy,
    output logic                       overrun,
    output logic                       bank
);

    his_pkg::hit_t     hit;
    his_pkg::mem_req_t mem_req;
    his_pkg::mem_rsp_t mem_rsp;
    logic              frame_done;
    logic              done_bank;

    // tdc code to tagged hit record
    photon_binner #(
        .N_BINS         (N_BINS),
        .BIN_SHIFT      (BIN_SHIFT),
        .N_PIXELS       (N_PIXELS),
        .HITS_PER_PIXEL (HITS_PER_PIXEL),
        .N_ACQ          (N_ACQ)
    ) i_binner (
        .clk        (clk),
        .combin_res (combin_res),
        .tdc_code   (tdc_code),
        .tdc_valid  (tdc_valid),
        .hit        (hit)
    );

    // two bank histogram store
    his_builder #(
        .N_BINS   (N_BINS),
        .N_PIXELS (N_PIXELS)
    ) i_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .frame_done (frame_done),
        .done_bank  (done_bank),
        .bank       (bank)
    );

    // closed bank streamed out bin by bin
    his_readout #(
        .N_BINS   (N_BINS),
        .N_PIXELS (N_PIXELS)
    ) i_readout (
        .clk        (clk),
        .combin_res (combin_res),
        .frame_done (frame_done),
        .done_bank  (done_bank),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .bin_out    (bin_out),
        .busy       (busy),
        .overrun    (overrun)
    );

endmodule

/* design/his_readout.sv */
`timescale 1ns/10ps

module his_readout #(
    parameter int N_BINS   = 16,
    parameter int N_PIXELS = 4
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 frame_done,
    input  logic                 done_bank,
    output his_pkg::mem_req_t    mem_req,
    input  his_pkg::mem_rsp_t    mem_rsp,
    output his_pkg::bin_word_t   bin_out,
    output logic                 busy,
    output logic                 overrun
);

    // tags of the request now waiting on its response
    typedef struct packed {
        logic                      bank;
        logic [his_pkg::PIX_W-1:0] pixel;
        logic [his_pkg::BIN_W-1:0] bin;
    } tag_t;

    logic bank_q;
    tag_t tag_q;
    logic last_bin;
    logic last_req;

    always_comb begin
        last_bin = (mem_req.bin == his_pkg::BIN_W'(N_BINS - 1));
        last_req = last_bin && (mem_req.pixel == his_pkg::PIX_W'(N_PIXELS - 1));
    end

    // address walker, one read and clear per cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            mem_req <= '0;
            busy    <= 1'b0;
            overrun <= 1'b0;
            bank_q  <= 1'b0;
        end else begin
            // a burst still running drops the new one
            if (frame_done && busy) begin
                overrun <= 1'b1;
            end

            if (!busy) begin
                if (frame_done) begin
                    busy          <= 1'b1;
                    bank_q        <= done_bank;
                    mem_req.rd    <= 1'b1;
                    mem_req.clr   <= 1'b1;
                    mem_req.pixel <= '0;
                    mem_req.bin   <= '0;
                end
            end else if (last_req) begin
                busy        <= 1'b0;
                mem_req.rd  <= 1'b0;
                mem_req.clr <= 1'b0;
            end else if (last_bin) begin
                // bin minor, next pixel
                mem_req.bin   <= '0;
                mem_req.pixel <= mem_req.pixel + 1'b1;
            end else begin
                mem_req.bin <= mem_req.bin + 1'b1;
            end
        end
    end

    // pair the response with the tags of its request
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            tag_q   <= '0;
            bin_out <= '0;
        end else begin
            tag_q.bank  <= bank_q;
            tag_q.pixel <= mem_req.pixel;
            tag_q.bin   <= mem_req.bin;

            bin_out.valid <= mem_rsp.valid;
            bin_out.bank  <= tag_q.bank;
            bin_out.pixel <= tag_q.pixel;
            bin_out.bin   <= tag_q.bin;
            bin_out.count <= mem_rsp.count;
        end
    end

    // builder answers only what was asked, one cycle late
    a_rsp_after_rd: assert property (@(posedge clk) disable iff (!combin_res)
        mem_rsp.valid |-> $past(mem_req.rd));

endmodule

/* design/his_builder.sv */
`timescale 1ns/10ps

module his_builder #(
    parameter int N_BINS   = 16,
    parameter int N_PIXELS = 4
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  his_pkg::hit_t        hit,
    input  his_pkg::mem_req_t    mem_req,
    output his_pkg::mem_rsp_t    mem_rsp,
    output logic                 frame_done,
    output logic                 done_bank,
    output logic                 bank
);

    // one bank is pixels times bins, two banks side by side
    localparam int DEPTH = N_PIXELS * N_BINS;
    localparam int AW    = $clog2(2 * DEPTH);

    // write stage of the increment pipe
    typedef struct packed {
        logic                      valid;
        logic [AW-1:0]             addr;
        logic [his_pkg::CNT_W-1:0] count;
    } wr_t;

    logic [his_pkg::CNT_W-1:0] mem [2*DEPTH];
    // set on first write, dropped by readout clear
    logic [2*DEPTH-1:0]        vld;
    wr_t                       wr_q;
    logic                      rd_bank;
    logic [AW-1:0]             hit_addr;
    logic [AW-1:0]             rd_addr;
    logic [his_pkg::CNT_W-1:0] hit_old;
    logic [his_pkg::CNT_W-1:0] hit_base;
    logic [his_pkg::CNT_W-1:0] hit_new;
    logic                      hit_fwd;

    // flat entry index, bank major then pixel then bin
    function automatic logic [AW-1:0] addr_of(
        input logic                      b,
        input logic [his_pkg::PIX_W-1:0] p,
        input logic [his_pkg::BIN_W-1:0] n
    );
        return AW'(int'(b) * DEPTH + int'(p) * N_BINS + int'(n));
    endfunction

    // readout always sees the bank not being filled
    assign rd_bank = ~bank;

    always_comb begin
        hit_addr = addr_of(hit.bank, hit.pixel, hit.bin);
        rd_addr  = addr_of(rd_bank, mem_req.pixel, mem_req.bin);
        // stale entries count as empty
        hit_old  = vld[hit_addr] ? mem[hit_addr] : '0;
        // previous hit to the same entry has not landed yet
        hit_fwd  = wr_q.valid && (wr_q.addr == hit_addr);
        hit_base = hit_fwd ? wr_q.count : hit_old;
        // hold at the top count
        if (hit_base == his_pkg::CNT_MAX) begin
            hit_new = hit_base;
        end else begin
            hit_new = hit_base + 1'b1;
        end
    end

    // counter storage
    always_ff @(posedge clk) begin
        if (wr_q.valid) begin
            mem[wr_q.addr] <= wr_q.count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_q       <= '0;
            vld        <= '0;
            frame_done <= 1'b0;
            done_bank  <= 1'b0;
            bank       <= 1'b0;
            mem_rsp    <= '0;
        end else begin
            // read cycle, result lands in the write stage
            wr_q.valid <= hit.valid;
            wr_q.addr  <= hit_addr;
            wr_q.count <= hit_new;

            // swap while the frame_end hit sits in the write stage
            frame_done <= hit.valid && hit.frame_end;
            if (hit.valid && hit.frame_end) begin
                done_bank <= bank;
                bank      <= ~bank;
            end

            // readout port, answered one cycle after rd
            mem_rsp.valid <= mem_req.rd;
            if (mem_req.rd && vld[rd_addr]) begin
                mem_rsp.count <= mem[rd_addr];
            end else begin
                mem_rsp.count <= '0;
            end
            if (mem_req.rd && mem_req.clr) begin
                vld[rd_addr] <= 1'b0;
            end

            // a landing write wins over a clear of the same entry
            if (wr_q.valid) begin
                vld[wr_q.addr] <= 1'b1;
            end
        end
    end

    // binner fill bank and readout bank never meet
    a_rd_not_fill: assert property (@(posedge clk) disable iff (!combin_res)
        (mem_req.rd && hit.valid) |-> (hit.bank != rd_bank));

    // frames are longer than one hit
    a_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done);

endmodule

/* design/photon_binner.sv */
`timescale 1ns/10ps

module photon_binner #(
    parameter int N_BINS         = 16,
    parameter int BIN_SHIFT      = 4,
    parameter int N_PIXELS       = 4,
    parameter int HITS_PER_PIXEL = 3,
    parameter int N_ACQ          = 6
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic [his_pkg::TDC_W-1:0]  tdc_code,
    input  logic                       tdc_valid,
    output his_pkg::hit_t              hit
);

    // counter widths with at least one bit each
    localparam int HCW = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int ACW = (N_ACQ > 1) ? $clog2(N_ACQ) : 1;

    logic [his_pkg::TDC_W-1:0] code_sh;
    logic [his_pkg::BIN_W-1:0] bin_c;
    logic [HCW-1:0]            hit_cnt;
    logic [his_pkg::PIX_W-1:0] pix_cnt;
    logic [ACW-1:0]            acq_cnt;
    logic                      fill_bank;
    logic                      last_hit;
    logic                      last_pix;
    logic                      last_acq;
    logic                      frame_last;

    // code to bin with a clamp at the top bin
    always_comb begin
        code_sh = tdc_code >> BIN_SHIFT;
        if (code_sh > his_pkg::TDC_W'(N_BINS - 1)) begin
            bin_c = his_pkg::BIN_W'(N_BINS - 1);
        end else begin
            bin_c = code_sh[his_pkg::BIN_W-1:0];
        end
    end

    // wrap points of the three nested counters
    always_comb begin
        last_hit   = (hit_cnt == HCW'(HITS_PER_PIXEL - 1));
        last_pix   = (pix_cnt == his_pkg::PIX_W'(N_PIXELS - 1));
        last_acq   = (acq_cnt == ACW'(N_ACQ - 1));
        frame_last = last_hit && last_pix && last_acq;
    end

    // hits within a pixel, then pixel, then acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt   <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            fill_bank <= 1'b0;
        end else if (tdc_valid) begin
            if (!last_hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                hit_cnt <= '0;
                if (!last_pix) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    pix_cnt <= '0;
                    if (!last_acq) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        // frame closed so the next hit goes to the other bank
                        acq_cnt   <= '0;
                        fill_bank <= ~fill_bank;
                    end
                end
            end
        end
    end

    // one record per strobe with tags taken before the counters move
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= '0;
        end else begin
            hit.valid <= tdc_valid;
            if (tdc_valid) begin
                hit.bank      <= fill_bank;
                hit.pixel     <= pix_cnt;
                hit.bin       <= bin_c;
                hit.frame_end <= frame_last;
            end
        end
    end

    // clamp keeps every bin inside the histogram
    a_bin_range: assert property (@(posedge clk) disable iff (!combin_res)
        hit.valid |-> (int'(hit.bin) < N_BINS));

endmodule

/* design/his_pkg.sv */
package his_pkg;

    // tdc arrival code width
    localparam int TDC_W = 8;

    // largest row the stages are sized for
    localparam int MAX_BINS   = 16;
    localparam int MAX_PIXELS = 8;

    // index widths follow the maximum sizes
    localparam int BIN_W = $clog2(MAX_BINS);
    localparam int PIX_W = $clog2(MAX_PIXELS);

    // bin counter width, saturates at all ones
    localparam int CNT_W = 8;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // binner -> builder, one tagged photon
    typedef struct packed {
        logic             valid;
        // bank being filled when the hit was taken
        logic             bank;
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
        // last hit of the frame
        logic             frame_end;
    } hit_t;

    // readout -> builder, one access to the closed bank
    typedef struct packed {
        logic             rd;
        // drop the valid bit of the entry after reading
        logic             clr;
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
    } mem_req_t;

    // builder -> readout, one cycle after rd
    typedef struct packed {
        logic             valid;
        // zero for an entry not written this frame
        logic [CNT_W-1:0] count;
    } mem_rsp_t;

    // output stream word
    typedef struct packed {
        logic             valid;
        logic             bank;
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
        logic [CNT_W-1:0] count;
    } bin_word_t;

endpackage
